// File: lsu_backend.f
logic/rv_types_pkg.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/regfile.sv
logic/dmem_arbiter.sv
logic/data_ram.sv
logic/lsu_backend.sv
testbench/lsu_backend_assert.sv
testbench/lsu_backend_tb.sv

// File: Makefile
# Verilator build and regression run for the RV32I back end

VERILATOR ?= verilator
TOP       ?= lsu_backend_tb
FILELIST  ?= lsu_backend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_TEXT ?= Regression passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Pass or fail is taken from the log, not from the simulator status
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/lsu_backend_tb.sv
// Testbench for the RV32I back end: directed writeback, load/store and host port tests
module lsu_backend_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_types_pkg::*;

    localparam int clk_period  = 40;
    localparam int test_cycles = 10 + 15 + 32 + 35 + 120 + 14;   // Reset, then tests 1 to 5

    logic        clk;
    logic        rst;
    logic        issue_valid;
    issue_t      issue;
    logic        host_req;
    logic        host_we;
    logic [31:0] host_addr;
    logic [31:0] host_wdata;
    logic [31:0] host_rdata;
    logic        host_resp;
    logic [4:0]  dbg_rs;
    logic [31:0] dbg_rv;
    logic        retire_valid;

    logic [7:0]  shadow_mem [dmem_words*4];   // Byte image of the data RAM
    logic [31:0] shadow_reg [32];
    logic [15:0] lfsr_q;
    int          err_cnt;
    int          test_err;
    int          test_cnt;

    lsu_backend dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((test_cycles + 50) * clk_period);
        $display("Watchdog expired, a test stopped making progress");
        $display("Regression failed");
        $finish;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1, one shift per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            err_cnt++;
            test_err++;
        end
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("Test %0d %s done, %0d mismatches", test_cnt, name, test_err);
        test_err = 0;
    endtask

    function automatic logic [31:0] shadow_word(input int waddr);
        return {shadow_mem[4*waddr+3], shadow_mem[4*waddr+2],
                shadow_mem[4*waddr+1], shadow_mem[4*waddr]};
    endfunction

    task automatic shadow_fill(input int waddr, input logic [31:0] data);
        for (int i = 0; i < 4; i++) begin
            shadow_mem[4*waddr+i] = data[8*i +: 8];
        end
    endtask

    // Load lanes come straight from the byte image
    function automatic logic [31:0] expect_rd(input issue_t t);
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        a = t.dmem_addr[9:0];
        b = shadow_mem[a];
        h = {shadow_mem[{a[9:1], 1'b1}], shadow_mem[{a[9:1], 1'b0}]};
        case (t.rd_m_sel)
            u_imm_rd:   return t.u_imm;
            alu_out_rd: return t.alu_out;
            ext_br:     return {31'd0, t.br_en};
            lb:         return {{24{b[7]}}, b};
            lbu:        return {24'd0, b};
            lh:         return {{16{h[15]}}, h};
            lhu:        return {16'd0, h};
            lw:         return shadow_word(a[9:2]);
            default:    return 32'd0;
        endcase
    endfunction

    task automatic predict(input issue_t t);
        logic [9:0] a;
        a = t.dmem_addr[9:0];
        case (t.mem_op)
            mem_store_b: shadow_mem[a] = t.store_data[7:0];
            mem_store_h: begin
                shadow_mem[{a[9:1], 1'b0}] = t.store_data[7:0];
                shadow_mem[{a[9:1], 1'b1}] = t.store_data[15:8];
            end
            mem_store_w: shadow_fill(a[9:2], t.store_data);
            default: ;
        endcase
        if (t.regf_we && t.rd_s != 5'd0) begin
            shadow_reg[t.rd_s] = expect_rd(t);
        end
    endtask

    function automatic issue_t make_op(input logic [4:0] rd, input rd_sel_t sel,
                                       input mem_op_t op, input logic [31:0] addr);
        issue_t t;
        t            = '0;
        t.rd_s       = rd;
        t.rd_m_sel   = sel;
        t.regf_we    = (sel != none);
        t.mem_op     = op;
        t.dmem_addr  = addr;
        t.alu_out    = rand_bits(32);
        t.u_imm      = rand_bits(20) << 12;
        t.store_data = rand_bits(32);
        t.br_en      = (rand_bits(1) != 0);
        return t;
    endfunction

    task automatic check_reg(input logic [4:0] r);
        dbg_rs = r;
        #1;
        check_val($sformatf("x%0d", r), dbg_rv, shadow_reg[r]);
    endtask

    // Register is readable three edges after the issue is driven
    task automatic run_op(input issue_t t);
        predict(t);
        issue       = t;
        issue_valid = 1'b1;
        step();
        issue_valid = 1'b0;
        step();
        step();
        if (t.regf_we) begin
            check_reg(t.rd_s);
        end
    endtask

    // Request held until host_resp
    task automatic host_access(input logic we, input int waddr, input logic [31:0] wdata,
                               output logic [31:0] rdata, output int waited);
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = waddr * 4;
        host_wdata = wdata;
        waited     = 0;
        do begin
            step();
            waited++;
        end while (!host_resp && waited < 20);
        if (!host_resp) begin
            $display("Host request to word %0d got no response", waddr);
            err_cnt++;
            test_err++;
        end
        rdata    = host_rdata;
        host_req = 1'b0;
        if (we) begin
            shadow_fill(waddr, wdata);
        end
    endtask

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------
    task automatic test_alu_wb();
        issue_t t;
        run_op(make_op(5'd1, alu_out_rd, mem_none, 0));
        run_op(make_op(5'd2, u_imm_rd, mem_none, 0));
        t       = make_op(5'd3, ext_br, mem_none, 0);
        t.br_en = 1'b1;
        run_op(t);
        t       = make_op(5'd4, ext_br, mem_none, 0);
        t.br_en = 1'b0;
        run_op(t);
        run_op(make_op(5'd0, alu_out_rd, mem_none, 0));   // x0 keeps zero
        finish_test("alu/u-imm/branch writeback");
    endtask

    task automatic test_host_rw();
        logic [31:0] rd;
        int          waited;
        for (int w = 0; w < 8; w++) begin
            host_access(1'b1, w * 33, rand_bits(32), rd, waited);
            step();
        end
        for (int w = 0; w < 8; w++) begin
            host_access(1'b0, w * 33, 32'd0, rd, waited);
            check_val("host_rdata", rd, shadow_word(w * 33));
            check_val("host wait cycles", waited, 1);
            step();
            check_val("host_resp", host_resp, 1'b0);   // One cycle only
        end
        finish_test("host write/read");
    endtask

    task automatic test_stores();
        mem_op_t     ops [7];
        int          offs [7];
        logic [31:0] rd;
        int          waited;
        int          w;
        ops  = '{mem_store_b, mem_store_b, mem_store_b, mem_store_b,
                 mem_store_h, mem_store_h, mem_store_w};
        offs = '{0, 1, 2, 3, 0, 2, 0};
        for (int k = 0; k < 7; k++) begin
            w = rand_bits(8);
            host_access(1'b1, w, rand_bits(32), rd, waited);   // Known background lanes
            run_op(make_op(5'd0, none, ops[k], w * 4 + offs[k]));
            host_access(1'b0, w, 32'd0, rd, waited);
            check_val("store readback", rd, shadow_word(w));
        end
        finish_test("byte/half/word stores");
    endtask

    task automatic test_loads();
        logic [31:0] pats [3];
        rd_sel_t     sels [5];
        int          sizes [5];
        logic [31:0] rd;
        int          waited;
        int          w;
        pats  = '{32'h807f_ff01, 32'h7f80_01ff, rand_bits(32)};
        sels  = '{lb, lbu, lh, lhu, lw};
        sizes = '{1, 1, 2, 2, 4};
        for (int p = 0; p < 3; p++) begin
            w = rand_bits(8);
            host_access(1'b1, w, pats[p], rd, waited);
            for (int s = 0; s < 5; s++) begin
                for (int off = 0; off < 4; off += sizes[s]) begin
                    run_op(make_op(5'(5 + s), sels[s], mem_load, w * 4 + off));
                end
            end
        end
        finish_test("loads with extension");
    endtask

    task automatic test_back_to_back();
        issue_t      ops [6];
        logic [31:0] rd;
        logic [31:0] host_data;
        int          waited;
        int          w;
        int          host_w;
        int          gnt;
        int          retired;
        w         = rand_bits(8);
        host_w    = (w + 128) % 256;
        host_data = rand_bits(32);
        host_access(1'b1, w, rand_bits(32), rd, waited);
        step();
        ops[0] = make_op(5'd10, none, mem_store_w, w * 4);
        ops[1] = make_op(5'd11, lw, mem_load, w * 4);
        ops[2] = make_op(5'd12, lbu, mem_load, w * 4 + 3);
        ops[3] = make_op(5'd13, alu_out_rd, mem_none, 0);
        ops[4] = make_op(5'd14, none, mem_store_b, w * 4 + 1);
        ops[5] = make_op(5'd15, lh, mem_load, w * 4);
        foreach (ops[i]) predict(ops[i]);
        gnt = 1;                             // First edge after an idle pipeline cycle
        while (gnt <= 6 && ops[gnt-1].mem_op != mem_none) begin
            gnt++;
        end
        retired = 0;
        for (int c = 0; c < 10; c++) begin
            issue_valid = (c < 6);
            if (c < 6) begin
                issue = ops[c];
            end
            if (c == 1) begin
                host_req   = 1'b1;
                host_we    = 1'b1;
                host_addr  = host_w * 4;
                host_wdata = host_data;
            end
            check_val("retire_valid", retire_valid, (c >= 2 && c < 8));
            check_val("host_resp", host_resp, (c == gnt + 1));
            if (host_resp) begin
                host_req = 1'b0;
            end
            retired += retire_valid;
            step();
        end
        shadow_fill(host_w, host_data);
        check_val("retired count", retired, 6);
        for (int r = 11; r < 16; r++) begin
            check_reg(5'(r));
        end
        host_access(1'b0, w, 32'd0, rd, waited);
        check_val("pipeline word", rd, shadow_word(w));
        host_access(1'b0, host_w, 32'd0, rd, waited);
        check_val("host word", rd, shadow_word(host_w));
        finish_test("back-to-back with held host");
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        lfsr_q      = 16'd8963;
        err_cnt     = 0;
        test_err    = 0;
        test_cnt    = 0;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        host_req    = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        dbg_rs      = '0;
        foreach (shadow_reg[i]) shadow_reg[i] = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        test_alu_wb();
        test_host_rw();
        test_stores();
        test_loads();
        test_back_to_back();
        err_cnt += dut0.chk0.assert_errs;
        $display("Summary: %0d tests, %0d errors (%0d from assertions)",
                 test_cnt, err_cnt, dut0.chk0.assert_errs);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: testbench/lsu_backend_assert.sv
// Bound checks on data RAM arbitration, response routing and writeback enable
module lsu_backend_assert (
    input logic                    clk,
    input logic                    rst,
    input rv_types_pkg::dmem_req_t pipe_req,
    input rv_types_pkg::dmem_req_t ram_req,
    input logic                    ram_resp,
    input logic                    pipe_resp,
    input logic                    host_resp,
    input logic                    regf_we
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_errs = 0;   // Assertion failures so far

    // Pipeline request answered next cycle, to the pipeline only
    resp_to_pipe: assert property (@(posedge clk) disable iff (rst)
        pipe_req.req |=> pipe_resp && !host_resp)
        else begin
            assert_errs++;
            $error("pipeline request not answered to the pipeline alone one cycle later");
        end

    // Granted host request answered next cycle, to the host only
    resp_to_host: assert property (@(posedge clk) disable iff (rst)
        ram_req.req && !pipe_req.req |=> host_resp && !pipe_resp)
        else begin
            assert_errs++;
            $error("host request not answered to the host alone one cycle later");
        end

    no_stray_resp: assert property (@(posedge clk) disable iff (rst) !ram_req.req |=> !ram_resp)
        else begin
            assert_errs++;
            $error("RAM response without a request");
        end

    wb_off_in_reset: assert property (@(posedge clk) rst |-> !regf_we)
        else begin
            assert_errs++;
            $error("register write enable high during reset");
        end

endmodule

bind lsu_backend lsu_backend_assert chk0 (
    .clk(clk), .rst(rst), .pipe_req(pipe_req), .ram_req(ram_req), .ram_resp(ram_resp),
    .pipe_resp(pipe_resp), .host_resp(host_resp), .regf_we(regf_we)
);

// File: logic/lsu_backend.sv
// RV32I back end top: memory and writeback stages, register file, shared data RAM
module lsu_backend (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  rv_types_pkg::issue_t issue,
    input  logic                 host_req,
    input  logic                 host_we,
    input  logic [31:0]          host_addr,    // Byte address
    input  logic [31:0]          host_wdata,
    output logic [31:0]          host_rdata,
    output logic                 host_resp,
    input  logic [4:0]           dbg_rs,
    output logic [31:0]          dbg_rv,
    output logic                 retire_valid
);
    import rv_types_pkg::*;

    dmem_req_t       pipe_req;
    dmem_req_t       host_req_s;
    dmem_req_t       ram_req;
    logic [xlen-1:0] ram_rdata;
    logic            ram_resp;
    logic [xlen-1:0] pipe_rdata;
    logic            pipe_resp;
    mem_wb_t         mem_wb;
    logic            regf_we;
    logic [4:0]      rd_sel;
    logic [xlen-1:0] rd_v;

    // ----------------------------------------------------------
    // Host port request, full words only
    // ----------------------------------------------------------
    always_comb begin
        host_req_s.req   = host_req;
        host_req_s.we    = host_we;
        host_req_s.addr  = host_addr[dmem_aw+1:2];
        host_req_s.wmask = host_we ? 4'b1111 : 4'b0000;
        host_req_s.wdata = host_wdata;
    end

    mem_stage u_mem_stage (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue(issue),
        .pipe_req(pipe_req), .pipe_resp(pipe_resp),
        .mem_wb(mem_wb)
    );

    wb_stage u_wb_stage (
        .rst(rst), .mem_wb(mem_wb),
        .dmem_rdata(pipe_rdata), .dmem_resp(pipe_resp),
        .regf_we(regf_we), .rd_sel(rd_sel), .rd_v(rd_v),
        .retire_valid(retire_valid)
    );

    regfile u_regfile (
        .clk(clk), .rst(rst),
        .regf_we(regf_we), .rd_sel(rd_sel), .rd_v(rd_v),
        .dbg_rs(dbg_rs), .dbg_rv(dbg_rv)
    );

    dmem_arbiter u_dmem_arbiter (
        .clk(clk), .rst(rst),
        .pipe_req(pipe_req), .host_req_s(host_req_s), .ram_req(ram_req),
        .ram_rdata(ram_rdata), .ram_resp(ram_resp),
        .pipe_rdata(pipe_rdata), .pipe_resp(pipe_resp),
        .host_rdata(host_rdata), .host_resp(host_resp)
    );

    data_ram u_data_ram (
        .clk(clk), .rst(rst),
        .ram_req(ram_req), .ram_rdata(ram_rdata), .ram_resp(ram_resp)
    );

endmodule

// File: logic/data_ram.sv
// Data RAM: word addressed, byte write mask, registered response one cycle after request
module data_ram (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_types_pkg::dmem_req_t ram_req,
    output logic [31:0]             ram_rdata,
    output logic                    ram_resp
);
    import rv_types_pkg::*;

    logic [3:0][7:0] mem [dmem_words];

    // Read returns the word as it was before a same-cycle write
    always_ff @(posedge clk) begin
        if (ram_req.req) begin
            ram_rdata <= mem[ram_req.addr];
            if (ram_req.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (ram_req.wmask[i]) begin
                        mem[ram_req.addr][i] <= ram_req.wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ram_resp <= 1'b0;
        end else begin
            ram_resp <= ram_req.req;           // Reads and writes both answer
        end
    end

endmodule

// File: logic/dmem_arbiter.sv
// Data RAM arbiter: pipeline over host at fixed priority, response steered by owner bit
module dmem_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_types_pkg::dmem_req_t pipe_req,
    input  rv_types_pkg::dmem_req_t host_req_s,
    output rv_types_pkg::dmem_req_t ram_req,
    input  logic [31:0]             ram_rdata,
    input  logic                    ram_resp,
    output logic [31:0]             pipe_rdata,
    output logic                    pipe_resp,
    output logic [31:0]             host_rdata,
    output logic                    host_resp
);

    logic pipe_gnt;
    logic host_gnt;
    logic owner_r;   // 1 when the access in flight belongs to the host

    // Pipeline cannot stall, host waits for an idle cycle
    assign pipe_gnt = pipe_req.req;
    // Host is not regranted while its own response is out
    assign host_gnt = host_req_s.req && !pipe_req.req && !host_resp;

    always_comb begin
        ram_req     = pipe_gnt ? pipe_req : host_req_s;
        ram_req.req = pipe_gnt || host_gnt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_r <= 1'b0;
        end else begin
            owner_r <= host_gnt;
        end
    end

    // ----------------------------------------------------------
    // Response routing
    // ----------------------------------------------------------
    assign pipe_resp  = ram_resp && !owner_r;
    assign host_resp  = ram_resp && owner_r;
    assign pipe_rdata = ram_rdata;
    assign host_rdata = ram_rdata;

endmodule

// File: logic/regfile.sv
// Integer register file: 32 x 32, x0 reads zero, one combinational debug read port
module regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic        regf_we,
    input  logic [4:0]  rd_sel,
    input  logic [31:0] rd_v,
    input  logic [4:0]  dbg_rs,
    output logic [31:0] dbg_rv
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regf_we && (rd_sel != 5'd0)) begin  // x0 is never written
            regs[rd_sel] <= rd_v;
        end
    end

    assign dbg_rv = regs[dbg_rs];

endmodule

// File: logic/wb_stage.sv
// Writeback stage: picks the rd value and extracts and extends loaded data
module wb_stage (
    input  logic                  rst,
    input  rv_types_pkg::mem_wb_t mem_wb,
    input  logic [31:0]           dmem_rdata,
    input  logic                  dmem_resp,
    output logic                  regf_we,
    output logic [4:0]            rd_sel,
    output logic [31:0]           rd_v,
    output logic                  retire_valid
);
    import rv_types_pkg::*;

    logic [1:0]  boff;
    logic [7:0]  ld_b;
    logic [15:0] ld_h;

    // Load lanes from the low address bits
    assign boff = mem_wb.dmem_addr_s[1:0];
    assign ld_b = dmem_rdata[8*boff +: 8];
    assign ld_h = dmem_rdata[16*boff[1] +: 16];

    // ----------------------------------------------------------
    // Register file write control
    // ----------------------------------------------------------
    always_comb begin
        rd_sel  = mem_wb.rd_s_s;
        regf_we = mem_wb.valid_s && mem_wb.regf_we_s;
        if (rst) begin
            regf_we = 1'b0;
        end
    end

    assign retire_valid = mem_wb.valid_s;

    // ----------------------------------------------------------
    // Result select
    // ----------------------------------------------------------
    always_comb begin
        rd_v = '0;
        case (mem_wb.rd_m_sel_s)
            u_imm_rd:   rd_v = mem_wb.u_imm_s;
            alu_out_rd: rd_v = mem_wb.alu_out_s;
            ext_br:     rd_v = {31'd0, mem_wb.br_en_s};
            lb: begin
                if (dmem_resp) rd_v = {{24{ld_b[7]}}, ld_b};
            end
            lbu: begin
                if (dmem_resp) rd_v = {24'd0, ld_b};
            end
            lh: begin
                if (dmem_resp) rd_v = {{16{ld_h[15]}}, ld_h};
            end
            lhu: begin
                if (dmem_resp) rd_v = {16'd0, ld_h};
            end
            lw: begin
                if (dmem_resp) rd_v = dmem_rdata;
            end
            default: rd_v = '0;                 // Stores write nothing
        endcase
    end

endmodule

// File: logic/mem_stage.sv
// Memory stage: ex/mem register, byte-lane load/store requests and mem/wb register
module mem_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  rv_types_pkg::issue_t    issue,
    output rv_types_pkg::dmem_req_t pipe_req,
    input  logic                    pipe_resp,
    output rv_types_pkg::mem_wb_t   mem_wb
);
    import rv_types_pkg::*;

    issue_t          ex_r;
    logic            ex_valid;
    logic [1:0]      boff;
    logic [xlen-1:0] sd;
    mem_wb_t         mem_wb_r;
    logic            acc_pend;  // Memory access sitting in mem/wb

    // ----------------------------------------------------------
    // Ex/mem register
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            ex_r <= issue;
        end
    end

    // ----------------------------------------------------------
    // Request formation
    // ----------------------------------------------------------
    assign boff = ex_r.dmem_addr[1:0];
    assign sd   = ex_r.store_data;

    always_comb begin
        pipe_req       = '0;
        pipe_req.req   = ex_valid && (ex_r.mem_op != mem_none);
        pipe_req.addr  = ex_r.dmem_addr[dmem_aw+1:2];
        case (ex_r.mem_op)
            mem_store_b: begin
                pipe_req.we    = 1'b1;
                pipe_req.wmask = 4'b0001 << boff;
                pipe_req.wdata = {4{sd[7:0]}};         // Replicated, mask picks the lane
            end
            mem_store_h: begin
                pipe_req.we    = 1'b1;
                pipe_req.wmask = 4'b0011 << {boff[1], 1'b0};
                pipe_req.wdata = {2{sd[15:0]}};
            end
            mem_store_w: begin
                pipe_req.we    = 1'b1;
                pipe_req.wmask = 4'b1111;
                pipe_req.wdata = sd;
            end
            default: ;                                  // Loads read the whole word
        endcase
    end

    // ----------------------------------------------------------
    // Mem/wb register
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb_r.valid_s <= 1'b0;
            acc_pend         <= 1'b0;
        end else begin
            mem_wb_r.valid_s     <= ex_valid;
            mem_wb_r.rd_s_s      <= ex_r.rd_s;
            mem_wb_r.rd_m_sel_s  <= ex_r.rd_m_sel;
            mem_wb_r.regf_we_s   <= ex_r.regf_we;
            mem_wb_r.alu_out_s   <= ex_r.alu_out;
            mem_wb_r.u_imm_s     <= ex_r.u_imm;
            mem_wb_r.br_en_s     <= ex_r.br_en;
            mem_wb_r.dmem_addr_s <= ex_r.dmem_addr;
            acc_pend             <= pipe_req.req;
        end
    end

    // A memory op retires only together with its RAM response
    always_comb begin
        mem_wb         = mem_wb_r;
        mem_wb.valid_s = mem_wb_r.valid_s && (!acc_pend || pipe_resp);
    end

endmodule

// File: logic/rv_types_pkg.sv
// RV32I back end shared types: sizes, writeback and memory op kinds, stage records
package rv_types_pkg;

    // ----------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------
    localparam int xlen       = 32;
    localparam int dmem_words = 256;                // Data RAM depth in words
    localparam int dmem_aw    = $clog2(dmem_words); // Word address width

    // ----------------------------------------------------------
    // Operation kinds
    // ----------------------------------------------------------

    // Source of the value written to rd
    typedef enum logic [3:0] {
        u_imm_rd,
        alu_out_rd,
        ext_br,      // Zero-extended branch compare bit
        lb,
        lbu,
        lh,
        lhu,
        lw,
        none         // Stores and anything without rd
    } rd_sel_t;

    typedef enum logic [2:0] {
        mem_none,
        mem_load,
        mem_store_b,
        mem_store_h,
        mem_store_w
    } mem_op_t;

    // ----------------------------------------------------------
    // Stage records
    // ----------------------------------------------------------

    // Executed instruction as handed over by the issuer
    typedef struct packed {
        logic [4:0]      rd_s;
        rd_sel_t         rd_m_sel;
        logic            regf_we;
        mem_op_t         mem_op;
        logic [xlen-1:0] alu_out;
        logic [xlen-1:0] u_imm;
        logic [xlen-1:0] dmem_addr;  // Byte address
        logic [xlen-1:0] store_data; // Unshifted, lanes placed in mem stage
        logic            br_en;
    } issue_t;

    typedef struct packed {
        logic            valid_s;
        logic [4:0]      rd_s_s;
        rd_sel_t         rd_m_sel_s;
        logic            regf_we_s;
        logic [xlen-1:0] alu_out_s;
        logic [xlen-1:0] u_imm_s;
        logic            br_en_s;
        logic [xlen-1:0] dmem_addr_s; // Low bits pick the load lane
    } mem_wb_t;

    // One data RAM access, word addressed with byte lanes
    typedef struct packed {
        logic               req;
        logic               we;
        logic [dmem_aw-1:0] addr;
        logic [3:0]         wmask;
        logic [xlen-1:0]    wdata;
    } dmem_req_t;

endpackage
